//--- hdl/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Data word width
`define XLEN 32

// Instruction memory depth and word address width
`define IMEM_WORDS 256
`define IMEM_AW    8

// Data memory depth and word address width
`define DMEM_WORDS 256
`define DMEM_AW    8

`endif

//--- hdl/isa_pkg.sv
package isa_pkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        op_reg   = 7'b0110011, // R-type ALU
        op_imm   = 7'b0010011, // I-type ALU and shifts
        op_load  = 7'b0000011, // lw
        op_store = 7'b0100011  // sw
    } opcode_t;

    // funct3 operation selector, shared by the ALU groups
    typedef enum logic [2:0] {
        f3_add_sub = 3'b000, // add, sub, addi
        f3_sll     = 3'b001,
        f3_slt     = 3'b010,
        f3_sltu    = 3'b011,
        f3_xor     = 3'b100,
        f3_srl_sra = 3'b101, // Bit 30 picks sra
        f3_or      = 3'b110,
        f3_and     = 3'b111
    } funct3_t;

    // Loads and stores reuse encoding 010 for the word width
    localparam funct3_t f3_word = f3_slt;

    // funct7 bit that selects sub and sra
    localparam int unsigned funct7_alt_bit = 30;

endpackage

//--- hdl/core_pkg.sv
package core_pkg;

    `include "rv_defs.svh"

    // Data word
    typedef logic [`XLEN-1:0] word_t;

    // Architectural register index
    typedef logic [4:0] reg_idx_t;

    // Byte address of an instruction
    typedef logic [31:0] pc_t;

    // ALU operations
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,  // Signed compare
        alu_sltu, // Unsigned compare
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

endpackage

//--- hdl/inst_mem.sv
`timescale 1ns/1ps

`include "rv_defs.svh"

module inst_mem
    import core_pkg::*;
(
    input  logic               CLK,
    input  logic               we,
    input  logic [`IMEM_AW-1:0] waddr,
    input  word_t              wdata,
    input  pc_t                raddr,
    output word_t              inst
);

    word_t mem [`IMEM_WORDS]; // Program storage

    logic [`IMEM_AW-1:0] fetch_idx;

    // Byte offset dropped, upper bits ignored so the PC wraps
    assign fetch_idx = raddr[`IMEM_AW+1:2];

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[waddr] <= wdata; // Load port, used while halted
        end
    end

    assign inst = mem[fetch_idx]; // Same-cycle fetch

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file
    import core_pkg::*;
(
    input  logic     CLK,
    input  logic     RST,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  word_t    wd,
    input  logic     we,
    output word_t    rd1,
    output word_t    rd2
);

    word_t regs [32];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != 5'd0)) begin
            regs[rd] <= wd; // x0 stays zero
        end
    end

    // Combinational reads; a write in flight shows up next cycle
    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

endmodule

//--- hdl/data_mem.sv
`timescale 1ns/1ps

`include "rv_defs.svh"

module data_mem
    import core_pkg::*;
(
    input  logic  CLK,
    input  word_t addr,
    input  logic  we,
    input  word_t wd,
    output word_t rd
);

    word_t mem [`DMEM_WORDS];

    logic [`DMEM_AW-1:0] idx;

    // Word index, low two address bits ignored
    assign idx = addr[`DMEM_AW+1:2];

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[idx] <= wd;
        end
    end

    assign rd = mem[idx]; // Asynchronous read for lw

endmodule

//--- hdl/decoder.sv
`timescale 1ns/1ps

module decoder
    import isa_pkg::*, core_pkg::*;
(
    input  word_t    inst,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output reg_idx_t rd,
    output word_t    imm,
    output alu_op_t  alu_op,
    output logic     use_imm,
    output logic     reg_we,
    output logic     mem_read,
    output logic     mem_write,
    output logic     illegal
);

    opcode_t opcode;
    funct3_t funct3;
    logic    alt;       // funct7 bit 30
    logic    f7_rest_0; // Remaining funct7 bits clear
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_shamt;
    logic    wr;        // Writes rd before x0 and legality filtering
    logic    bad;

    assign opcode    = opcode_t'(inst[6:0]);
    assign funct3    = funct3_t'(inst[14:12]);
    assign alt       = inst[funct7_alt_bit];
    assign f7_rest_0 = ({inst[31], inst[29:25]} == 6'd0);

    assign imm_i     = {{20{inst[31]}}, inst[31:20]};
    assign imm_s     = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_shamt = {27'd0, inst[24:20]}; // Shifts use only shamt

    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    always_comb begin
        imm       = imm_i;
        alu_op    = alu_add;
        use_imm   = 1'b0;
        wr        = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        bad       = 1'b0;

        case (opcode)
            op_reg: begin
                wr = 1'b1;
                // Only add/sub and srl/sra accept the alternate funct7
                bad = !f7_rest_0 ||
                      (alt && (funct3 != f3_add_sub) && (funct3 != f3_srl_sra));
                case (funct3)
                    f3_add_sub: alu_op = alt ? alu_sub : alu_add;
                    f3_sll:     alu_op = alu_sll;
                    f3_slt:     alu_op = alu_slt;
                    f3_sltu:    alu_op = alu_sltu;
                    f3_xor:     alu_op = alu_xor;
                    f3_srl_sra: alu_op = alt ? alu_sra : alu_srl;
                    f3_or:      alu_op = alu_or;
                    f3_and:     alu_op = alu_and;
                    default:    bad = 1'b1;
                endcase
            end
            op_imm: begin
                wr      = 1'b1;
                use_imm = 1'b1;
                case (funct3)
                    f3_add_sub: alu_op = alu_add; // No subi
                    f3_sll: begin
                        alu_op = alu_sll;
                        imm    = imm_shamt;
                        bad    = !f7_rest_0 || alt;
                    end
                    f3_slt:     alu_op = alu_slt;
                    f3_sltu:    alu_op = alu_sltu;
                    f3_xor:     alu_op = alu_xor;
                    f3_srl_sra: begin
                        alu_op = alt ? alu_sra : alu_srl;
                        imm    = imm_shamt;
                        bad    = !f7_rest_0;
                    end
                    f3_or:      alu_op = alu_or;
                    f3_and:     alu_op = alu_and;
                    default:    bad = 1'b1;
                endcase
            end
            op_load: begin
                use_imm  = 1'b1; // Address is rs1 + imm
                wr       = 1'b1;
                mem_read = 1'b1;
                bad      = (funct3 != f3_word);
            end
            op_store: begin
                use_imm   = 1'b1;
                imm       = imm_s;
                mem_write = 1'b1;
                bad       = (funct3 != f3_word);
            end
            default: bad = 1'b1;
        endcase

        // Unsupported encodings retire as no-ops
        if (bad) begin
            wr        = 1'b0;
            mem_read  = 1'b0;
            mem_write = 1'b0;
        end
    end

    assign reg_we  = wr && (rd != 5'd0);
    assign illegal = bad;

endmodule

//--- hdl/alu.sv
`timescale 1ns/1ps

module alu
    import core_pkg::*;
(
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   y
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0]; // Upper shift bits ignored
    assign lt_s  = ($signed(a) < $signed(b));
    assign lt_u  = (a < b);

    always_comb begin
        case (op)
            alu_add:  y = a + b;
            alu_sub:  y = a - b;
            alu_sll:  y = a << shamt;
            alu_slt:  y = {31'd0, lt_s};
            alu_sltu: y = {31'd0, lt_u};
            alu_xor:  y = a ^ b;
            alu_srl:  y = a >> shamt;
            alu_sra:  y = word_t'($signed(a) >>> shamt); // Sign fill
            alu_or:   y = a | b;
            alu_and:  y = a & b;
            default:  y = '0;
        endcase
    end

endmodule

//--- hdl/single_cpu.sv
`timescale 1ns/1ps

`include "rv_defs.svh"

module single_cpu
    import core_pkg::*;
(
    input  logic               CLK,
    input  logic               RST,
    input  logic               run,
    input  logic               imem_we,
    input  logic [`IMEM_AW-1:0] imem_addr,
    input  word_t              imem_data,
    output logic               ret_valid,
    output pc_t                ret_pc,
    output word_t              ret_inst,
    output logic               ret_we,
    output reg_idx_t           ret_rd,
    output word_t              ret_data,
    output logic               ret_illegal
);

    pc_t                 pc;
    pc_t                 pc_next;
    logic [`IMEM_AW-1:0] pc_word_next;
    logic                active;   // Executing this cycle

    word_t    inst;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm;
    alu_op_t  alu_op;
    logic     use_imm;
    logic     reg_we;
    logic     mem_read;
    logic     mem_write;
    logic     illegal;

    word_t rd1;
    word_t rd2;
    word_t alu_b;
    word_t alu_y;
    word_t mem_rd;
    word_t wb_data;
    logic  rf_we;
    logic  dm_we;

    assign active = run && !RST;

    // Next word index wraps at the end of instruction memory
    assign pc_word_next = pc[`IMEM_AW+1:2] + 1'b1;
    assign pc_next      = pc_t'({pc_word_next, 2'b00});

    always_ff @(posedge CLK) begin
        if (RST) begin
            pc <= '0;
        end else if (run) begin
            pc <= pc_next;
        end
    end

    inst_mem i_imem (
        .CLK   (CLK),
        .we    (imem_we),
        .waddr (imem_addr),
        .wdata (imem_data),
        .raddr (pc),
        .inst  (inst)
    );

    decoder i_dec (
        .inst      (inst),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .imm       (imm),
        .alu_op    (alu_op),
        .use_imm   (use_imm),
        .reg_we    (reg_we),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .illegal   (illegal)
    );

    assign rf_we = reg_we && active;    // Writes only while running
    assign dm_we = mem_write && active;

    reg_file i_rf (
        .CLK (CLK),
        .RST (RST),
        .rs1 (rs1),
        .rs2 (rs2),
        .rd  (rd),
        .wd  (wb_data),
        .we  (rf_we),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    assign alu_b = use_imm ? imm : rd2;

    alu i_alu (
        .op (alu_op),
        .a  (rd1),
        .b  (alu_b),
        .y  (alu_y)
    );

    // ALU result doubles as the lw/sw address
    data_mem i_dmem (
        .CLK  (CLK),
        .addr (alu_y),
        .we   (dm_we),
        .wd   (rd2),
        .rd   (mem_rd)
    );

    assign wb_data = mem_read ? mem_rd : alu_y;

    // Retire view of the executing instruction
    assign ret_valid   = active;
    assign ret_pc      = pc;
    assign ret_inst    = inst;
    assign ret_we      = rf_we;
    assign ret_rd      = rd;
    assign ret_data    = wb_data;
    assign ret_illegal = illegal && active;

endmodule

//--- sim/single_cpu_props.sv
`timescale 1ns/1ps

module single_cpu_props
    import core_pkg::*;
(
    input logic     CLK,
    input logic     RST,
    input logic     ret_valid,
    input pc_t      ret_pc,
    input logic     ret_we,
    input reg_idx_t ret_rd,
    input logic     ret_illegal,
    input logic     rf_we,
    input logic     dm_we
);

    a_no_write_in_reset: assert property (@(posedge CLK) RST |-> !rf_we && !dm_we && !ret_we)
        else $error("write enable high during reset");

    // Next word address, wrapping at the end of instruction memory
    a_pc_advance: assert property (@(posedge CLK) disable iff (RST)
        $past(ret_valid) |-> ret_pc == pc_t'({$past(ret_pc[9:2]) + 8'd1, 2'b00}))
        else $error("ret_pc did not advance by 4 after a retirement");

    a_pc_hold: assert property (@(posedge CLK) disable iff (RST)
        !$past(ret_valid) |-> ret_pc == $past(ret_pc))
        else $error("ret_pc moved while the core was halted");

    a_we_legal: assert property (@(posedge CLK) ret_we |-> (ret_rd != 5'd0) && !ret_illegal)
        else $error("ret_we high for x0 or an illegal instruction");

endmodule

bind single_cpu single_cpu_props i_props (
    .CLK         (CLK),
    .RST         (RST),
    .ret_valid   (ret_valid),
    .ret_pc      (ret_pc),
    .ret_we      (ret_we),
    .ret_rd      (ret_rd),
    .ret_illegal (ret_illegal),
    .rf_we       (rf_we),
    .dm_we       (dm_we)
);

//--- sim/tb_single_cpu.sv
`timescale 1ns/1ps

`include "rv_defs.svh"

module tb_single_cpu
    import isa_pkg::*, core_pkg::*;
();

    logic CLK;
    logic RST;
    logic run;
    logic imem_we;
    logic [`IMEM_AW-1:0] imem_addr;
    word_t imem_data;
    word_t ret_inst;
    word_t ret_data;
    pc_t ret_pc;
    logic ret_valid;
    logic ret_we;
    logic ret_illegal;
    reg_idx_t ret_rd;

    logic [31:0] lfsr = 32'h19af_3449;
    word_t m_regs [32];               // Reference register file
    word_t m_mem [`DMEM_WORDS];       // Reference data memory
    logic [7:0] m_pcw;                // Reference PC word index
    pc_t last_pc;                     // PC of the previous retirement
    bit wrap_seen;
    logic written [`DMEM_WORDS];
    word_t prog [`IMEM_WORDS];
    int n;
    int errors;
    int test_errs;
    int tests_failed;

    single_cpu i_dut (.*);

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    function automatic logic [31:0] rand_bits(input int bits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < bits; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1); // One step per bit
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic reg_idx_t pick_reg();
        return reg_idx_t'(rand_bits(5));
    endfunction

    function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                     input reg_idx_t rd, input reg_idx_t rs1,
                                     input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input logic [2:0] f3,
                                     input reg_idx_t rd, input reg_idx_t rs1, input opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(input logic [11:0] imm, input logic [2:0] f3,
                                     input reg_idx_t rs1, input reg_idx_t rs2);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic word_t gen_r();
        logic [2:0] f3;
        logic alt;
        f3  = 3'(rand_bits(3));
        alt = rand_bits(1) && (f3 == f3_add_sub || f3 == f3_srl_sra); // sub and sra only
        return r_type(alt ? 7'h20 : 7'h00, f3, pick_reg(), pick_reg(), pick_reg());
    endfunction

    function automatic word_t gen_i();
        logic [2:0] f3;
        logic [11:0] imm;
        f3  = 3'(rand_bits(3));
        imm = 12'(rand_bits(12));
        if (f3 == f3_sll) imm = {7'h00, imm[4:0]};
        if (f3 == f3_srl_sra) imm = {imm[11] ? 7'h20 : 7'h00, imm[4:0]};
        return i_type(imm, f3, pick_reg(), pick_reg(), op_imm);
    endfunction

    function automatic word_t alu_ref(input funct3_t f3, input logic alt, input word_t a,
                                      input word_t b);
        case (f3)
            f3_add_sub: return alt ? a - b : a + b;
            f3_sll:     return a << b[4:0];
            f3_slt:     return {31'd0, $signed(a) < $signed(b)};
            f3_sltu:    return {31'd0, a < b};
            f3_xor:     return a ^ b;
            f3_srl_sra: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            f3_or:      return a | b;
            default:    return a & b;
        endcase
    endfunction

    // Executes one instruction on the reference state
    task automatic model_exec(input word_t inst, output logic we, output word_t data,
                              output logic ill);
        opcode_t opc;
        funct3_t f3;
        logic [6:0] f7;
        word_t a;
        word_t imm_i;
        word_t imm_s;
        word_t addr;
        opc   = opcode_t'(inst[6:0]);
        f3    = funct3_t'(inst[14:12]);
        f7    = inst[31:25];
        a     = m_regs[inst[19:15]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        data  = '0;
        ill   = 1'b0;
        case (opc)
            op_reg: begin
                ill  = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == f3_add_sub || f3 == f3_srl_sra)));
                data = alu_ref(f3, f7 == 7'h20, a, m_regs[inst[24:20]]);
            end
            op_imm: begin
                if (f3 == f3_sll) ill = (f7 != 7'h00);
                if (f3 == f3_srl_sra) ill = !(f7 == 7'h00 || f7 == 7'h20);
                data = alu_ref(f3, f3 == f3_srl_sra && f7 == 7'h20, a, imm_i);
            end
            op_load: begin
                ill  = (f3 != f3_word);
                addr = a + imm_i;
                data = m_mem[addr[9:2]];
            end
            op_store: begin
                ill  = (f3 != f3_word);
                addr = a + imm_s;
                if (!ill) m_mem[addr[9:2]] = m_regs[inst[24:20]];
            end
            default: ill = 1'b1;
        endcase
        we = !ill && (opc != op_store) && (inst[11:7] != 5'd0);
        if (we) m_regs[inst[11:7]] = data;
        m_pcw = m_pcw + 8'd1;
    endtask

    task automatic compare(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            errors++;
            $display("error %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic retire_check(input word_t inst);
        logic ex_we, ex_ill;
        word_t ex_data;
        compare("ret_valid", 32'd1, {31'd0, ret_valid});
        compare("ret_pc", {22'd0, m_pcw, 2'b00}, ret_pc);
        if (last_pc == 32'h0000_03fc && ret_pc == 32'h0) wrap_seen = 1'b1; // Fetch wrapped
        last_pc = ret_pc;
        compare("ret_inst", inst, ret_inst);
        model_exec(inst, ex_we, ex_data, ex_ill);
        compare("ret_rd", {27'd0, inst[11:7]}, {27'd0, ret_rd});
        compare("ret_we", {31'd0, ex_we}, {31'd0, ret_we});
        compare("ret_illegal", {31'd0, ex_ill}, {31'd0, ret_illegal});
        if (ex_we) compare("ret_data", ex_data, ret_data);
    endtask

    // Loads prog[0..n-1] at the model PC, then runs it with a retire check per cycle
    task automatic load_and_run();
        bit seen;
        for (int i = 0; i < n; i++) begin
            @(posedge CLK);
            imem_we   <= 1'b1;
            imem_addr <= m_pcw + i[7:0];
            imem_data <= prog[i];
        end
        @(posedge CLK);
        imem_we <= 1'b0;
        run     <= 1'b1;
        seen = 1'b0;
        for (int k = 0; k < 8 && !seen; k++) begin
            @(negedge CLK);
            seen = ret_valid;
        end
        if (!seen) begin
            errors++;
            $display("timeout: core never reported a retirement after run went high");
            run <= 1'b0;
        end else begin
            for (int i = 0; i < n; i++) begin
                retire_check(prog[i]);
                @(posedge CLK);
                if (i == n - 1) run <= 1'b0;
                else @(negedge CLK);
            end
        end
    endtask

    task automatic push(input word_t w);
        prog[n] = w;
        n++;
    endtask

    task automatic reg_dump(); // or xk, xk, x0 exposes each register
        for (int k = 1; k < 32; k++) push(r_type(7'h00, f3_or, k[4:0], k[4:0], 5'd0));
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, errors - test_errs);
        if (errors != test_errs) tests_failed++;
        test_errs = errors;
        n = 0;
    endtask

    initial begin
        logic [7:0] w;
        logic [6:0] opc;
        logic [7:0] held;
        RST = 1'b1;
        run = 1'b0;
        imem_we = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        for (int i = 0; i < 32; i++) m_regs[i] = '0;
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            m_mem[i] = '0;
            written[i] = 1'b0;
        end
        m_pcw = '0;
        last_pc = '0;
        wrap_seen = 1'b0;
        n = 0;
        errors = 0;
        test_errs = 0;
        tests_failed = 0;
        repeat (4) @(posedge CLK);
        RST <= 1'b0;

        for (int k = 1; k < 32; k++) begin
            push(i_type(12'(rand_bits(12)), f3_add_sub, k[4:0], 5'd0, op_imm));
        end
        for (int i = 0; i < 200; i++) push(gen_r());
        load_and_run();
        end_test(1, "register-register ALU");

        for (int i = 0; i < 200; i++) push(gen_i());
        load_and_run();
        end_test(2, "immediate ALU and shifts");

        for (int i = 0; i < 100; i++) begin
            w = 8'(rand_bits(8));
            if (i == 0 || rand_bits(1)) begin
                written[w] = 1'b1;
                push(s_type({2'b00, w, 2'b00}, f3_word, 5'd0, pick_reg()));
            end else begin
                while (!written[w]) w = w + 8'd1; // Nearest stored word
                push(i_type({2'b00, w, 2'b00}, f3_word, pick_reg(), 5'd0, op_load));
            end
        end
        load_and_run();
        end_test(3, "loads and stores");

        for (int i = 0; i < 40; i++) begin
            case (rand_bits(2))
                0: push(i_type(12'(rand_bits(12)), f3_add_sub, 5'd0, pick_reg(), op_imm));
                1: push(r_type(7'h00, f3_add_sub, 5'd0, pick_reg(), pick_reg()));
                2: begin
                    opc = 7'(rand_bits(7));
                    while (opc == op_reg || opc == op_imm || opc == op_load || opc == op_store)
                        opc = 7'(rand_bits(7));
                    push((rand_bits(25) << 7) | word_t'(opc));
                end
                default: push(r_type(7'h00, f3_add_sub, pick_reg(), 5'd0, 5'd0));
            endcase
        end
        reg_dump();
        load_and_run();
        end_test(4, "x0 and illegal encodings");

        held = m_pcw;
        repeat (5) begin
            @(negedge CLK);
            compare("ret_valid", 32'd0, {31'd0, ret_valid});
            compare("ret_pc", {22'd0, held, 2'b00}, ret_pc);
        end
        for (int i = 0; i < (256 - m_pcw) + 16 && i < `IMEM_WORDS; i++)
            push(rand_bits(1) ? gen_r() : gen_i());
        wrap_seen = 1'b0;
        load_and_run();
        if (!wrap_seen) begin
            errors++;
            $display("program did not continue at PC 0 after the last instruction word");
        end
        end_test(5, "run control and wrap");

        $display("tests failed %0d of 5, check errors %0d", tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- single_cpu.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/inst_mem.sv
hdl/reg_file.sv
hdl/data_mem.sv
hdl/decoder.sv
hdl/alu.sv
hdl/single_cpu.sv
sim/single_cpu_props.sv
sim/tb_single_cpu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the single_cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_single_cpu -f single_cpu.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_single_cpu 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx '>>> PASS' <<< "$output"; then
    exit 0
fi
exit 1
